/* source/rom_params.svh */
`ifndef ROM_PARAMS_SVH
`define ROM_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Download channel and store geometry
//////////////////////////////////////////////////////////////////////

`define ROM_IOCTL_AW   25
`define ROM_PROG_AW    17                  // Program store holds 16-bit words.
`define ROM_TILE_AW    14                  // Tile store holds 24-bit words.
`define ROM_PROG_DEPTH (1 << `ROM_PROG_AW)
`define ROM_TILE_DEPTH (1 << `ROM_TILE_AW)

//////////////////////////////////////////////////////////////////////
// Region bases
//////////////////////////////////////////////////////////////////////

`define ROM_TILE_BASE  17'h1A000           // Byte address in the download stream.
`define ROM_SPR_BASE   17'h10000           // Word offset of the sprite CPU code.
`define ROM_SND_BASE   17'h08000           // Word offset of the sound CPU code.
`define ROM_TILE_SKIP  2'd3                // Fourth tile lane has no storage.

`endif

/* source/rom_pkg.sv */
package rom_pkg;

	//////////////////////////////////////////////////////////////////////
	// Store data types
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] rom_byte_t;

	// Byte lane inside a store word.
	typedef logic [1:0] lane_t;

	typedef logic [15:0] prog_word_t;      // Two lanes, low byte at even addresses.
	typedef logic [23:0] tile_word_t;      // Three lanes from the merged tile ROMs.

	//////////////////////////////////////////////////////////////////////
	// Program store read clients
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		CLIENT_CPU = 2'd0,
		CLIENT_SPR = 2'd1,
		CLIENT_SND = 2'd2
	} rom_client_e;

endpackage

/* source/rom_download_mapper.sv */
`timescale 1ns/1ps
`include "rom_params.svh"

module rom_download_mapper import rom_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [`ROM_IOCTL_AW-1:0] ioctl_addr,
	input  rom_byte_t                ioctl_dout,
	output logic                     prog_wr_req,
	output logic [`ROM_PROG_AW-1:0]  prog_wr_addr,
	output lane_t                    prog_wr_lane,
	output rom_byte_t                prog_wr_byte,
	input  logic                     prog_wr_ack,
	output logic                     tile_wr_req,
	output logic [`ROM_TILE_AW-1:0]  tile_wr_addr,
	output lane_t                    tile_wr_lane,
	output rom_byte_t                tile_wr_byte,
	input  logic                     tile_wr_ack
);

	localparam int NPORT = 2;              // Port 0 is the program store, port 1 the tiles.

	logic                      wr_d;
	logic [1:0]                since_cnt;
	logic                      stroke;
	logic                      accept;
	logic                      is_prog;
	logic [`ROM_TILE_AW+1:0]   tile_off;
	logic [NPORT-1:0]          hit;
	logic [NPORT-1:0]          ack;
	logic [NPORT-1:0]          free;
	logic [NPORT-1:0]          req_q;
	logic [NPORT-1:0]          pend_q;
	logic [`ROM_PROG_AW-1:0]   new_addr [NPORT];
	lane_t                     new_lane [NPORT];
	logic [`ROM_PROG_AW-1:0]   out_addr [NPORT];
	lane_t                     out_lane [NPORT];
	rom_byte_t                 out_byte [NPORT];
	logic [`ROM_PROG_AW-1:0]   pend_addr [NPORT];
	lane_t                     pend_lane [NPORT];
	rom_byte_t                 pend_byte [NPORT];

	//////////////////////////////////////////////////////////////////////
	// Strobe detection and spacing
	//////////////////////////////////////////////////////////////////////

	assign stroke = ioctl_download & ioctl_wr & ~wr_d;
	assign accept = stroke & (since_cnt == 2'd3);  // Strokes closer than 3 cycles are lost.

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_d      <= 1'b0;
			since_cnt <= 2'd3;
		end else begin
			wr_d <= ioctl_wr;
			if (accept)
				since_cnt <= 2'd1;
			else if (since_cnt != 2'd3)
				since_cnt <= since_cnt + 2'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Region rule
	//////////////////////////////////////////////////////////////////////

	assign is_prog  = ioctl_addr < `ROM_IOCTL_AW'(`ROM_TILE_BASE);
	assign tile_off = (`ROM_TILE_AW+2)'(ioctl_addr - `ROM_IOCTL_AW'(`ROM_TILE_BASE));

	assign new_addr[0] = ioctl_addr[`ROM_PROG_AW:1];
	assign new_lane[0] = {1'b0, ioctl_addr[0]};
	assign new_addr[1] = `ROM_PROG_AW'(tile_off[`ROM_TILE_AW-1:0]);
	assign new_lane[1] = tile_off[`ROM_TILE_AW+1:`ROM_TILE_AW];  // Upper offset bits pick the ROM.

	assign hit[0] = accept & is_prog;
	assign hit[1] = accept & ~is_prog & (new_lane[1] != `ROM_TILE_SKIP);

	//////////////////////////////////////////////////////////////////////
	// Toggle request ports with a one-entry hold buffer
	//////////////////////////////////////////////////////////////////////

	assign ack  = {tile_wr_ack, prog_wr_ack};
	assign free = ~(req_q ^ ack);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req_q  <= '0;
			pend_q <= '0;
		end else begin
			for (int p = 0; p < NPORT; p++) begin
				if (pend_q[p] && free[p]) begin
					req_q[p]  <= ~req_q[p];
					pend_q[p] <= 1'b0;
				end
				if (hit[p]) begin
					if (free[p] && !pend_q[p])
						req_q[p] <= ~req_q[p];
					else if (!pend_q[p] || free[p])
						pend_q[p] <= 1'b1;  // Buffered until the store catches up.
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int p = 0; p < NPORT; p++) begin
			if (pend_q[p] && free[p]) begin
				out_addr[p] <= pend_addr[p];
				out_lane[p] <= pend_lane[p];
				out_byte[p] <= pend_byte[p];
			end
			if (hit[p]) begin
				if (free[p] && !pend_q[p]) begin
					out_addr[p] <= new_addr[p];
					out_lane[p] <= new_lane[p];
					out_byte[p] <= ioctl_dout;
				end else if (!pend_q[p] || free[p]) begin
					pend_addr[p] <= new_addr[p];
					pend_lane[p] <= new_lane[p];
					pend_byte[p] <= ioctl_dout;
				end
			end
		end
	end

	assign prog_wr_req  = req_q[0];
	assign prog_wr_addr = out_addr[0];
	assign prog_wr_lane = out_lane[0];
	assign prog_wr_byte = out_byte[0];
	assign tile_wr_req  = req_q[1];
	assign tile_wr_addr = out_addr[1][`ROM_TILE_AW-1:0];
	assign tile_wr_lane = out_lane[1];
	assign tile_wr_byte = out_byte[1];

	// Download strobes need at least three cycles between rising edges.
	a_strobe_spacing: assert property (@(posedge clk_sys) disable iff (!rst_n)
		stroke |=> !stroke ##1 !stroke)
		else $error("ioctl_wr strobes closer than 3 cycles");

endmodule

/* source/rom_store.sv */
`timescale 1ns/1ps

module rom_store import rom_pkg::*; #(
	parameter type         word_t = prog_word_t,
	parameter int unsigned DEPTH  = 1024
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     wr_req,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  lane_t                    wr_lane,
	input  rom_byte_t                wr_byte,
	output logic                     wr_ack,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output word_t                    rd_data
);

	localparam int LANES = $bits(word_t) / 8;

	word_t mem [DEPTH];
	logic  wr_pend;

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	assign wr_pend = wr_req ^ wr_ack;     // A toggle from the mapper starts a write.

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			wr_ack <= 1'b0;
		else if (wr_pend)
			wr_ack <= wr_req;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_pend) begin
			for (int l = 0; l < LANES; l++) begin
				if (wr_lane == l)
					mem[wr_addr][l*8 +: 8] <= wr_byte;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];          // One cycle of read latency.
	end

	// The mapper only sends lanes the word has, and each write closes in one cycle.
	a_lane_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_pend |-> (int'(wr_lane) < LANES) ##1 !wr_pend)
		else $error("store write lane %0d out of range or handshake stuck", wr_lane);

endmodule

/* source/rom_read_arbiter.sv */
`timescale 1ns/1ps
`include "rom_params.svh"

module rom_read_arbiter import rom_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    loading,
	input  logic [15:0]             cpu_addr,
	input  logic                    cpu_req,
	input  logic [14:0]             spr_addr,
	input  logic                    spr_req,
	input  logic [12:0]             snd_addr,
	input  logic                    snd_req,
	output rom_byte_t               cpu_data,
	output logic                    cpu_valid,
	output rom_byte_t               spr_data,
	output logic                    spr_valid,
	output rom_byte_t               snd_data,
	output logic                    snd_valid,
	output logic [`ROM_PROG_AW-1:0] mem_addr,
	input  prog_word_t              mem_data
);

	localparam int NCLI = 3;

	logic [NCLI-1:0]         req_in;
	logic [NCLI-1:0]         pend_q;
	logic [NCLI-1:0]         want;
	logic [NCLI-1:0]         grant_oh;
	logic [NCLI-1:0]         live_lane;
	logic [NCLI-1:0]         hold_lane;
	logic [`ROM_PROG_AW-1:0] live_waddr [NCLI];
	logic [`ROM_PROG_AW-1:0] hold_waddr [NCLI];
	logic                    gnt_any;
	rom_client_e             gnt_id;
	rom_client_e             last_q;
	logic                    gnt_lane;
	logic                    s1_valid;
	rom_client_e             s1_id;
	logic                    s1_lane;
	logic [NCLI-1:0]         valid_q;
	rom_byte_t               data_q [NCLI];

	//////////////////////////////////////////////////////////////////////
	// Client word addresses
	//////////////////////////////////////////////////////////////////////

	assign req_in    = {snd_req, spr_req, cpu_req};
	assign live_lane = {snd_addr[0], spr_addr[0], cpu_addr[0]};

	assign live_waddr[CLIENT_CPU] = `ROM_PROG_AW'(cpu_addr[15:1]);
	assign live_waddr[CLIENT_SPR] = `ROM_SPR_BASE + `ROM_PROG_AW'(spr_addr[14:1]);
	assign live_waddr[CLIENT_SND] = `ROM_SND_BASE + `ROM_PROG_AW'(snd_addr[12:1]);

	// A fresh request competes in the cycle it arrives.
	assign want = pend_q | req_in;

	//////////////////////////////////////////////////////////////////////
	// Round-robin grant
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int idx;
		gnt_any = 1'b0;
		gnt_id  = last_q;
		for (int k = 1; k <= NCLI; k++) begin
			idx = (int'(last_q) + k) % NCLI;
			if (!gnt_any && want[idx] && !loading) begin
				gnt_any = 1'b1;
				gnt_id  = rom_client_e'(idx);
			end
		end
	end

	assign grant_oh = gnt_any ? (NCLI'(1) << gnt_id) : '0;
	assign mem_addr = req_in[gnt_id] ? live_waddr[gnt_id] : hold_waddr[gnt_id];
	assign gnt_lane = req_in[gnt_id] ? live_lane[gnt_id] : hold_lane[gnt_id];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pend_q   <= '0;
			last_q   <= CLIENT_SND;           // CPU wins the first round.
			s1_valid <= 1'b0;
			valid_q  <= '0;
		end else begin
			pend_q   <= want & ~grant_oh;
			s1_valid <= gnt_any;
			if (gnt_any)
				last_q <= gnt_id;
			for (int c = 0; c < NCLI; c++)
				valid_q[c] <= s1_valid && (s1_id == c);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address hold and byte return
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		for (int c = 0; c < NCLI; c++) begin
			if (req_in[c]) begin
				hold_waddr[c] <= live_waddr[c];
				hold_lane[c]  <= live_lane[c];
			end
			if (s1_valid && (s1_id == c))
				data_q[c] <= s1_lane ? mem_data[15:8] : mem_data[7:0];
		end
		s1_id   <= gnt_id;
		s1_lane <= gnt_lane;
	end

	assign cpu_valid = valid_q[CLIENT_CPU];
	assign spr_valid = valid_q[CLIENT_SPR];
	assign snd_valid = valid_q[CLIENT_SND];
	assign cpu_data  = data_q[CLIENT_CPU];
	assign spr_data  = data_q[CLIENT_SPR];
	assign snd_data  = data_q[CLIENT_SND];

	// Nothing is granted while loading, so no byte returns two cycles later.
	a_no_valid_loading: assert property (@(posedge clk_sys) disable iff (!rst_n)
		loading |-> ##2 (valid_q == '0))
		else $error("read valid returned for a grant made during download");

endmodule

/* source/core_reset_ctrl.sv */
`timescale 1ns/1ps

module core_reset_ctrl (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic ioctl_download,
	input  logic status_reset,
	input  logic button_reset,
	output logic rom_loaded,
	output logic core_reset
);

	logic download_d;

	//////////////////////////////////////////////////////////////////////
	// Download completion and core reset
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;               // Core stays in reset until ROMs arrive.
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download)
				rom_loaded <= 1'b1;           // Sticky once the first download ends.
			core_reset <= status_reset | button_reset | ~rom_loaded;
		end
	end

endmodule

/* source/rom_subsystem.sv */
`timescale 1ns/1ps
`include "rom_params.svh"

module rom_subsystem import rom_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [`ROM_IOCTL_AW-1:0] ioctl_addr,
	input  rom_byte_t                ioctl_dout,
	input  logic                     status_reset,
	input  logic                     button_reset,
	input  logic [15:0]              cpu_addr,
	input  logic                     cpu_req,
	output rom_byte_t                cpu_data,
	output logic                     cpu_valid,
	input  logic [14:0]              spr_addr,
	input  logic                     spr_req,
	output rom_byte_t                spr_data,
	output logic                     spr_valid,
	input  logic [12:0]              snd_addr,
	input  logic                     snd_req,
	output rom_byte_t                snd_data,
	output logic                     snd_valid,
	input  logic [`ROM_TILE_AW-1:0]  tile_addr,
	output tile_word_t               tile_data,
	output logic                     rom_loaded,
	output logic                     core_reset
);

	logic                    prog_wr_req;
	logic [`ROM_PROG_AW-1:0] prog_wr_addr;
	lane_t                   prog_wr_lane;
	rom_byte_t               prog_wr_byte;
	logic                    prog_wr_ack;
	logic                    tile_wr_req;
	logic [`ROM_TILE_AW-1:0] tile_wr_addr;
	lane_t                   tile_wr_lane;
	rom_byte_t               tile_wr_byte;
	logic                    tile_wr_ack;
	logic [`ROM_PROG_AW-1:0] prog_rd_addr;
	prog_word_t              prog_rd_data;

	//////////////////////////////////////////////////////////////////////
	// Download path
	//////////////////////////////////////////////////////////////////////

	rom_download_mapper mapper0 (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.prog_wr_req    (prog_wr_req),
		.prog_wr_addr   (prog_wr_addr),
		.prog_wr_lane   (prog_wr_lane),
		.prog_wr_byte   (prog_wr_byte),
		.prog_wr_ack    (prog_wr_ack),
		.tile_wr_req    (tile_wr_req),
		.tile_wr_addr   (tile_wr_addr),
		.tile_wr_lane   (tile_wr_lane),
		.tile_wr_byte   (tile_wr_byte),
		.tile_wr_ack    (tile_wr_ack)
	);

	rom_store #(.word_t(prog_word_t), .DEPTH(`ROM_PROG_DEPTH)) prog_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr_req  (prog_wr_req),
		.wr_addr (prog_wr_addr),
		.wr_lane (prog_wr_lane),
		.wr_byte (prog_wr_byte),
		.wr_ack  (prog_wr_ack),
		.rd_addr (prog_rd_addr),
		.rd_data (prog_rd_data)
	);

	// Tile reads are direct; data is only meaningful outside a download.
	rom_store #(.word_t(tile_word_t), .DEPTH(`ROM_TILE_DEPTH)) tile_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr_req  (tile_wr_req),
		.wr_addr (tile_wr_addr),
		.wr_lane (tile_wr_lane),
		.wr_byte (tile_wr_byte),
		.wr_ack  (tile_wr_ack),
		.rd_addr (tile_addr),
		.rd_data (tile_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Fetch side and core reset
	//////////////////////////////////////////////////////////////////////

	rom_read_arbiter arbiter0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.loading   (ioctl_download),
		.cpu_addr  (cpu_addr),
		.cpu_req   (cpu_req),
		.spr_addr  (spr_addr),
		.spr_req   (spr_req),
		.snd_addr  (snd_addr),
		.snd_req   (snd_req),
		.cpu_data  (cpu_data),
		.cpu_valid (cpu_valid),
		.spr_data  (spr_data),
		.spr_valid (spr_valid),
		.snd_data  (snd_data),
		.snd_valid (snd_valid),
		.mem_addr  (prog_rd_addr),
		.mem_data  (prog_rd_data)
	);

	core_reset_ctrl reset_ctrl0 (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

endmodule

/* dv/rom_subsystem_tb.sv */
`timescale 1ns/1ps
`include "rom_params.svh"

module rom_subsystem_tb import rom_pkg::*; ();

	localparam int N_CPU       = 24;
	localparam int N_SND       = 16;
	localparam int N_OTHER     = 8;
	localparam int N_TILE      = 12;
	localparam int N_STROKES   = N_CPU + N_SND + N_OTHER + 4 * N_TILE;
	localparam int N_SINGLE    = 30;
	localparam int N_TRIPLE    = 10;
	localparam int N_FETCH     = N_SINGLE + N_TRIPLE + 1 + N_TILE;
	localparam int CYCLE_LIMIT = N_STROKES * 4 + N_FETCH * 8 + 200;
	localparam int TILE_LANE   = 1 << `ROM_TILE_AW;

	logic        clk_sys;
	logic        rst_n;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	rom_byte_t   ioctl_dout;
	logic        status_reset;
	logic        button_reset;
	logic [15:0] cpu_addr;
	logic        cpu_req;
	rom_byte_t   cpu_data;
	logic        cpu_valid;
	logic [14:0] spr_addr;
	logic        spr_req;
	rom_byte_t   spr_data;
	logic        spr_valid;
	logic [12:0] snd_addr;
	logic        snd_req;
	rom_byte_t   snd_data;
	logic        snd_valid;
	logic [`ROM_TILE_AW-1:0] tile_addr;
	tile_word_t  tile_data;
	logic        rom_loaded;
	logic        core_reset;

	rom_byte_t prog_model [0:262143];     // Indexed by word * 2 + lane.
	rom_byte_t tile_model [0:3*TILE_LANE-1];  // Indexed by lane * 16384 + word.
	int        cpu_q [$];
	int        snd_q [$];
	int        tile_q [$];
	int        errors    = 0;
	int        checks    = 0;
	int        cycle_cnt = 0;

	rom_subsystem dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#1;                                // Outputs are settled, inputs change here.
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic fail_note(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic download_byte(input int addr, input rom_byte_t data);
		int off;
		ioctl_addr = addr[24:0];
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		step();
		ioctl_wr = 1'b0;
		repeat (3) step();                 // Strobes four cycles apart.
		check_value("core_reset", core_reset, 1);
		if (addr < `ROM_TILE_BASE) begin
			prog_model[addr] = data;
		end else begin
			off = addr - `ROM_TILE_BASE;
			if (off[15:14] != 2'd3)
				tile_model[off[15:0]] = data;
		end
	endtask

	// Issues one request per enabled client and watches every valid for limit cycles.
	task automatic fetch(input logic [2:0] en, input logic [15:0] ca, input logic [14:0] sa,
		input logic [12:0] na, input int drop_dl, input int limit);
		logic [2:0] seen;
		logic [2:0] vld;
		rom_byte_t  got [3];
		int         idx [3];
		string      name [3];
		name[CLIENT_CPU] = "cpu_data";
		name[CLIENT_SPR] = "spr_data";
		name[CLIENT_SND] = "snd_data";
		idx[CLIENT_CPU]  = 2 * (ca >> 1) + ca[0];
		idx[CLIENT_SPR]  = 2 * (`ROM_SPR_BASE + (sa >> 1)) + sa[0];
		idx[CLIENT_SND]  = 2 * (`ROM_SND_BASE + (na >> 1)) + na[0];
		seen     = 3'b000;
		cpu_addr = ca;
		spr_addr = sa;
		snd_addr = na;
		{snd_req, spr_req, cpu_req} = en;
		for (int n = 1; n <= limit; n++) begin
			step();
			vld = {snd_valid, spr_valid, cpu_valid};
			got[CLIENT_CPU] = cpu_data;
			got[CLIENT_SPR] = spr_data;
			got[CLIENT_SND] = snd_data;
			for (int c = 0; c < 3; c++) begin
				if (vld[c]) begin
					if (!en[c] || seen[c])
						fail_note($sformatf("Extra read valid for client %0d at cycle %0d", c, n));
					if (ioctl_download)
						fail_note($sformatf("Client %0d got a read valid during download", c));
					seen[c] = 1'b1;
					// Sprite code lies past the download, so its window reads unwritten words.
					check_value(name[c], got[c], prog_model[idx[c]]);
				end
			end
			if (n == 1)
				{snd_req, spr_req, cpu_req} = 3'b000;
			if (n == drop_dl)
				ioctl_download = 1'b0;
		end
		for (int c = 0; c < 3; c++) begin
			if (en[c] && !seen[c])
				fail_note($sformatf("Client %0d got no read valid within %0d cycles", c, limit));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int        seed;
		int        a;
		int        w;
		int        k;
		logic [2:0] en;
		seed           = $urandom(87);
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		status_reset   = 1'b0;
		button_reset   = 1'b0;
		{cpu_addr, cpu_req, spr_addr, spr_req, snd_addr, snd_req} = '0;
		tile_addr      = '0;
		repeat (4) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		step();
		check_value("core_reset", core_reset, 1);
		check_value("rom_loaded", rom_loaded, 0);
		check_value("valids", {snd_valid, spr_valid, cpu_valid}, 0);

		ioctl_download = 1'b1;
		step();
		for (k = 0; k < N_CPU; k++) begin
			a = $urandom_range(16'hFFFF);
			download_byte(a, $urandom);
			cpu_q.push_back(a);
		end
		for (k = 0; k < N_SND; k++) begin
			a = 'h10000 + $urandom_range(13'h1FFF);
			download_byte(a, $urandom);
			snd_q.push_back(a);
		end
		for (k = 0; k < N_OTHER; k++)
			download_byte('h12000 + $urandom_range(16'h7FFF), $urandom);
		for (k = 0; k < N_TILE; k++) begin
			w = $urandom_range(TILE_LANE - 1);
			for (int l = 0; l < 3; l++)
				download_byte(`ROM_TILE_BASE + l * TILE_LANE + w, $urandom);
			download_byte(`ROM_TILE_BASE + 3 * TILE_LANE + w, ~tile_model[w]);  // Lane 3 is dropped.
			tile_q.push_back(w);
		end
		ioctl_download = 1'b0;

		k = 0;
		while (rom_loaded !== 1'b1 && k < 8) begin
			step();
			k++;
		end
		if (rom_loaded !== 1'b1)
			fail_note("rom_loaded did not rise after the download ended");
		check_value("core_reset", core_reset, 1);
		step();
		check_value("core_reset", core_reset, 0);

		foreach (tile_q[i]) begin
			tile_addr = tile_q[i];
			step();
			check_value("tile_data", tile_data, {tile_model[2 * TILE_LANE + tile_q[i]],
				tile_model[TILE_LANE + tile_q[i]], tile_model[tile_q[i]]});
		end

		// Sprite offsets reuse written CPU addresses, so a missing base would return CPU code.
		for (k = 0; k < N_SINGLE + N_TRIPLE; k++) begin
			en = (k < N_SINGLE) ? 3'b001 << $urandom_range(2) : 3'b111;
			fetch(en, cpu_q[$urandom_range(cpu_q.size() - 1)],
				cpu_q[$urandom_range(cpu_q.size() - 1)],
				snd_q[$urandom_range(snd_q.size() - 1)] - 'h10000, 0, 4);
		end

		// Requests wait while a download is running.
		ioctl_download = 1'b1;
		step();
		fetch(3'b111, cpu_q[0], cpu_q[0], snd_q[0] - 'h10000, 8, 12);

		status_reset = 1'b1;
		step();
		check_value("core_reset", core_reset, 1);
		status_reset = 1'b0;
		step();
		check_value("core_reset", core_reset, 0);
		button_reset = 1'b1;
		step();
		check_value("core_reset", core_reset, 1);
		button_reset = 1'b0;
		step();
		check_value("core_reset", core_reset, 0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+source
source/rom_pkg.sv
source/rom_download_mapper.sv
source/rom_store.sv
source/rom_read_arbiter.sv
source/core_reset_ctrl.sv
source/rom_subsystem.sv
dv/rom_subsystem_tb.sv

/* Bender.yml */
package:
  name: rom_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/rom_pkg.sv
      - source/rom_download_mapper.sv
      - source/rom_store.sv
      - source/rom_read_arbiter.sv
      - source/core_reset_ctrl.sv
      - source/rom_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/rom_subsystem_tb.sv
